// File: cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// bus widths
`define CART_ADDR_W 24
`define ROM_ADDR_W 23
`define RAM_ADDR_W 19

// access delay counts, ADDR state lasts count + 1 cycles
`define ROM_CYCLE_LEN 7
`define RAM_CYCLE_LEN 5

// bank region e0-e7 selects save ram
`define RAM_REGION 5'b11100

// snes line synchronizer depth
`define SYNC_DEPTH 8

// about 1 ms of stopped cpu clock
`define DEAD_TIMEOUT_DEF 96000

`endif

// File: cart_pkg.sv
`include "cart_params.svh"

package cart_pkg;

  typedef logic [`CART_ADDR_W-1:0] cart_addr_t;
  typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;
  typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [7:0] byte_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [3:0] dly_cnt_t;

  // rom sequencer
  typedef enum logic [1:0] {
    rom_idle,
    rom_rd_addr,
    rom_wr_addr,
    rom_end
  } rom_state_t;

  // save ram sequencer
  typedef enum logic [1:0] {
    ram_idle,
    ram_rd_addr,
    ram_wr_addr,
    ram_end
  } ram_state_t;

endpackage

// File: cart_if.sv
`timescale 1ns/1ns

// filtered snes bus, from the synchronizer to its users
interface snes_bus_if;
  import cart_pkg::*;

  logic cycle_start;
  logic cycle_end;
  logic rd_start;
  // levels, low means active
  logic read;
  logic romsel;
  logic cpu_clk;
  cart_addr_t addr;

  modport src (
    output cycle_start, cycle_end, rd_start, read, romsel, cpu_clk, addr
  );

  modport dst (
    input cycle_start, cycle_end, rd_start, read, romsel, cpu_clk, addr
  );

endinterface

// one mcu request channel towards a memory sequencer
interface mem_req_if;
  import cart_pkg::*;

  logic rrq;
  logic wrq;
  cart_addr_t addr;
  byte_t wdata;
  byte_t rdata;
  logic done;

  modport master (output rrq, wrq, addr, wdata, input rdata, done);

  modport slave (input rrq, wrq, addr, wdata, output rdata, done);

endinterface

// File: snes_bus_sync.sv
`timescale 1ns/1ns
`include "cart_params.svh"

module snes_bus_sync (
  input  logic                 CLK2,
  input  logic                 arst_n,
  input  cart_pkg::cart_addr_t snes_addr,
  input  logic                 snes_read_n,
  input  logic                 snes_romsel_n,
  input  logic                 snes_cpu_clk,
  snes_bus_if.src              bus
);
  import cart_pkg::*;

  localparam int ADDR_STAGES = 7;

  logic [`SYNC_DEPTH-1:0] read_sr;
  logic [`SYNC_DEPTH-1:0] romsel_sr;
  logic [`SYNC_DEPTH-1:0] cpu_sr;
  cart_addr_t addr_sr [ADDR_STAGES];

  // --------------------
  // control line history
  // --------------------

  // newest sample in bit 0
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      read_sr <= '1;
      romsel_sr <= '1;
      cpu_sr <= '0;
    end else begin
      read_sr <= {read_sr[`SYNC_DEPTH-2:0], snes_read_n};
      romsel_sr <= {romsel_sr[`SYNC_DEPTH-2:0], snes_romsel_n};
      cpu_sr <= {cpu_sr[`SYNC_DEPTH-2:0], snes_cpu_clk};
    end
  end

  // address settles slower than the control lines
  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr;
    for (int i = 1; i < ADDR_STAGES; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  // --------------------
  // filtered levels
  // --------------------

  // two-tap and vote
  assign bus.read = read_sr[2] & read_sr[1];
  assign bus.romsel = romsel_sr[2] & romsel_sr[1];
  assign bus.cpu_clk = cpu_sr[2] & cpu_sr[1];
  assign bus.addr = addr_sr[ADDR_STAGES-1] & addr_sr[ADDR_STAGES-2];

  // --------------------
  // edge strobes
  // --------------------

  // cpu clock rising
  assign bus.cycle_start =
    ((cpu_sr[`SYNC_DEPTH-1:2] & cpu_sr[`SYNC_DEPTH-2:1]) == 6'b000011);

  // cpu clock falling, end of the snes cycle
  assign bus.cycle_end =
    ((cpu_sr[`SYNC_DEPTH-1:2] | cpu_sr[`SYNC_DEPTH-2:1]) == 6'b111000);

  // read line falling
  assign bus.rd_start =
    ((read_sr[`SYNC_DEPTH-1:2] | read_sr[`SYNC_DEPTH-2:1]) == 6'b111100);

endmodule

// File: snes_dead_watch.sv
`timescale 1ns/1ns
`include "cart_params.svh"

module snes_dead_watch #(
  parameter int DEAD_TIMEOUT = `DEAD_TIMEOUT_DEF
) (
  input  logic    CLK2,
  input  logic    arst_n,
  snes_bus_if.dst bus,
  output logic    dead,
  output logic    abort,
  output logic    snes_reset_strobe
);

  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);

  logic [CNT_W-1:0] idle_cnt;
  logic revive;

  // stops counting once dead, so no wrap
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      idle_cnt <= '0;
      dead <= 1'b1;
      revive <= 1'b0;
    end else begin
      revive <= 1'b0;
      if (bus.cpu_clk) begin
        idle_cnt <= '0;
        dead <= 1'b0;
        // clock back after a dead period
        if (dead) revive <= 1'b1;
      end else if (idle_cnt > CNT_W'(DEAD_TIMEOUT)) begin
        dead <= 1'b1;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

  assign abort = revive;
  assign snes_reset_strobe = revive;

endmodule

// File: mcu_req_router.sv
`timescale 1ns/1ns
`include "cart_params.svh"

module mcu_req_router (
  input  logic                 CLK2,
  input  logic                 arst_n,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  input  cart_pkg::cart_addr_t mcu_addr,
  input  cart_pkg::byte_t      mcu_wdata,
  output cart_pkg::byte_t      mcu_rdata,
  output logic                 mcu_rdy,
  mem_req_if.master            rom,
  mem_req_if.master            ram
);

  logic ram_hit;
  logic rom_rdy;
  logic ram_rdy;

  // region decode on the top five bank bits
  assign ram_hit = (mcu_addr[`CART_ADDR_W-1 -: 5] == `RAM_REGION);

  assign rom.rrq = mcu_rrq & ~ram_hit;
  assign rom.wrq = mcu_wrq & ~ram_hit;
  assign rom.addr = mcu_addr;
  assign rom.wdata = mcu_wdata;

  assign ram.rrq = mcu_rrq & ram_hit;
  assign ram.wrq = mcu_wrq & ram_hit;
  assign ram.addr = mcu_addr;
  assign ram.wdata = mcu_wdata;

  // --------------------
  // ready tracking
  // --------------------

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rom_rdy <= 1'b1;
      ram_rdy <= 1'b1;
    end else begin
      if (rom.rrq | rom.wrq) rom_rdy <= 1'b0;
      else if (rom.done) rom_rdy <= 1'b1;

      if (ram.rrq | ram.wrq) ram_rdy <= 1'b0;
      else if (ram.done) ram_rdy <= 1'b1;
    end
  end

  assign mcu_rdy = rom_rdy & ram_rdy;

  // read data from whichever side just finished
  always_ff @(posedge CLK2) begin
    if (rom.done) begin
      mcu_rdata <= rom.rdata;
    end else if (ram.done) begin
      mcu_rdata <= ram.rdata;
    end
  end

endmodule

// File: rom_arbiter.sv
`timescale 1ns/1ns
`include "cart_params.svh"

module rom_arbiter (
  input  logic                CLK2,
  input  logic                arst_n,
  snes_bus_if.dst             bus,
  input  logic                dead,
  input  logic                abort,
  mem_req_if.slave            req,
  output cart_pkg::rom_addr_t rom_addr,
  input  cart_pkg::rom_word_t rom_rdata,
  output cart_pkg::rom_word_t rom_wdata,
  output logic                rom_data_oe,
  output logic                rom_we_n,
  output logic                rom_bhe_n,
  output logic                rom_ble_n,
  output cart_pkg::byte_t     snes_rdata
);
  import cart_pkg::*;

  rom_state_t rom_state;
  dly_cnt_t dly_cnt;
  logic rd_pend;
  logic wr_pend;
  cart_addr_t mcu_addr_q;
  byte_t mcu_wdata_q;
  byte_t rdata_q;
  logic free_slot;
  logic mcu_hit;
  logic wr_hit;
  logic addr0;

  // no new access right as a rom read begins
  assign free_slot = (bus.cycle_end | bus.romsel | dead) & ~(bus.rd_start & ~bus.romsel);

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else if (req.rrq) begin
      rd_pend <= 1'b1;
    end else if (req.wrq) begin
      wr_pend <= 1'b1;
    end else if (rom_state == rom_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end
  end

  always_ff @(posedge CLK2) begin
    if (req.rrq | req.wrq) begin
      mcu_addr_q <= req.addr;
      mcu_wdata_q <= req.wdata;
    end
  end

  // --------------------
  // sequencer
  // --------------------

  // abort leaves the pending flags set, so the access is retried
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rom_state <= rom_idle;
      dly_cnt <= '0;
    end else if (abort) begin
      rom_state <= rom_idle;
    end else begin
      case (rom_state)
        rom_idle: begin
          if (free_slot & rd_pend) begin
            rom_state <= rom_rd_addr;
            dly_cnt <= dly_cnt_t'(`ROM_CYCLE_LEN);
          end else if (free_slot & wr_pend) begin
            rom_state <= rom_wr_addr;
            dly_cnt <= dly_cnt_t'(`ROM_CYCLE_LEN);
          end
        end
        rom_rd_addr, rom_wr_addr: begin
          dly_cnt <= dly_cnt - 1'b1;
          if (dly_cnt == '0) rom_state <= rom_end;
        end
        default: rom_state <= rom_idle;
      endcase
    end
  end

  // last sample before END is the one handed back
  always_ff @(posedge CLK2) begin
    if (rom_state == rom_rd_addr) begin
      rdata_q <= addr0 ? rom_rdata[7:0] : rom_rdata[15:8];
    end
  end

  assign req.rdata = rdata_q;
  assign req.done = (rom_state == rom_end);

  // --------------------
  // rom pins
  // --------------------

  assign wr_hit = (rom_state == rom_wr_addr);
  assign mcu_hit = (rom_state == rom_rd_addr) | wr_hit;
  assign rom_addr = mcu_hit ? mcu_addr_q[`CART_ADDR_W-1:1] : bus.addr[`CART_ADDR_W-1:1];
  assign addr0 = mcu_hit ? mcu_addr_q[0] : bus.addr[0];

  // odd address uses the low byte lane
  assign rom_bhe_n = addr0;
  assign rom_ble_n = ~addr0;
  assign rom_wdata = addr0 ? {8'h00, mcu_wdata_q} : {mcu_wdata_q, 8'h00};
  assign rom_data_oe = wr_hit;
  assign rom_we_n = ~wr_hit;

  assign snes_rdata = bus.addr[0] ? rom_rdata[7:0] : rom_rdata[15:8];

endmodule

// File: ram_arbiter.sv
`timescale 1ns/1ns
`include "cart_params.svh"

module ram_arbiter (
  input  logic                CLK2,
  input  logic                arst_n,
  snes_bus_if.dst             bus,
  input  logic                dead,
  input  logic                abort,
  mem_req_if.slave            req,
  output cart_pkg::ram_addr_t ram_addr,
  input  cart_pkg::byte_t     ram_rdata,
  output cart_pkg::byte_t     ram_wdata,
  output logic                ram_data_oe,
  output logic                ram_we_n
);
  import cart_pkg::*;

  ram_state_t ram_state;
  dly_cnt_t dly_cnt;
  logic rd_pend;
  logic wr_pend;
  ram_addr_t mcu_addr_q;
  byte_t mcu_wdata_q;
  byte_t rdata_q;
  logic free_slot;
  logic wr_hit;
  logic mcu_hit;

  assign free_slot = bus.cycle_end | dead;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else if (req.rrq) begin
      rd_pend <= 1'b1;
    end else if (req.wrq) begin
      wr_pend <= 1'b1;
    end else if (ram_state == ram_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end
  end

  always_ff @(posedge CLK2) begin
    if (req.rrq | req.wrq) begin
      mcu_addr_q <= req.addr[`RAM_ADDR_W-1:0];
      mcu_wdata_q <= req.wdata;
    end
  end

  // --------------------
  // sequencer
  // --------------------

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      ram_state <= ram_idle;
      dly_cnt <= '0;
    end else if (abort) begin
      ram_state <= ram_idle;
    end else begin
      case (ram_state)
        ram_idle: begin
          if (free_slot & rd_pend) begin
            ram_state <= ram_rd_addr;
            dly_cnt <= dly_cnt_t'(`RAM_CYCLE_LEN);
          end else if (free_slot & wr_pend) begin
            ram_state <= ram_wr_addr;
            dly_cnt <= dly_cnt_t'(`RAM_CYCLE_LEN);
          end
        end
        ram_rd_addr, ram_wr_addr: begin
          dly_cnt <= dly_cnt - 1'b1;
          if (dly_cnt == '0) ram_state <= ram_end;
        end
        default: ram_state <= ram_idle;
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (ram_state == ram_rd_addr) rdata_q <= ram_rdata;
  end

  assign req.rdata = rdata_q;
  assign req.done = (ram_state == ram_end);

  // ram pins
  assign wr_hit = (ram_state == ram_wr_addr);
  assign mcu_hit = (ram_state == ram_rd_addr) | wr_hit;
  assign ram_addr = mcu_hit ? mcu_addr_q : bus.addr[`RAM_ADDR_W-1:0];
  assign ram_wdata = mcu_wdata_q;
  assign ram_data_oe = wr_hit;
  assign ram_we_n = ~wr_hit;

endmodule

// File: cart_mem_top.sv
`timescale 1ns/1ns
`include "cart_params.svh"

module cart_mem_top #(
  parameter int DEAD_TIMEOUT = `DEAD_TIMEOUT_DEF
) (
  input  logic                 CLK2,
  input  logic                 arst_n,
  // snes side
  input  cart_pkg::cart_addr_t snes_addr,
  input  logic                 snes_read_n,
  input  logic                 snes_romsel_n,
  input  logic                 snes_cpu_clk,
  output cart_pkg::byte_t      snes_data_out,
  output logic                 snes_data_oe,
  output logic                 snes_reset_strobe,
  // mcu side
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  input  cart_pkg::cart_addr_t mcu_addr,
  input  cart_pkg::byte_t      mcu_wdata,
  output cart_pkg::byte_t      mcu_rdata,
  output logic                 mcu_rdy,
  // rom
  output cart_pkg::rom_addr_t  rom_addr,
  input  cart_pkg::rom_word_t  rom_rdata,
  output cart_pkg::rom_word_t  rom_wdata,
  output logic                 rom_data_oe,
  output logic                 rom_we_n,
  output logic                 rom_bhe_n,
  output logic                 rom_ble_n,
  // save ram
  output cart_pkg::ram_addr_t  ram_addr,
  input  cart_pkg::byte_t      ram_rdata,
  output cart_pkg::byte_t      ram_wdata,
  output logic                 ram_data_oe,
  output logic                 ram_we_n
);

  logic dead;
  logic abort;

  snes_bus_if snes_bus ();
  mem_req_if rom_req ();
  mem_req_if ram_req ();

  snes_bus_sync snes_bus_sync_inst (
    .CLK2(CLK2), .arst_n(arst_n), .snes_addr(snes_addr), .snes_read_n(snes_read_n),
    .snes_romsel_n(snes_romsel_n), .snes_cpu_clk(snes_cpu_clk), .bus(snes_bus)
  );

  snes_dead_watch #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) snes_dead_watch_inst (
    .CLK2(CLK2), .arst_n(arst_n), .bus(snes_bus), .dead(dead), .abort(abort),
    .snes_reset_strobe(snes_reset_strobe)
  );

  mcu_req_router mcu_req_router_inst (
    .CLK2(CLK2), .arst_n(arst_n), .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq),
    .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata), .mcu_rdata(mcu_rdata),
    .mcu_rdy(mcu_rdy), .rom(rom_req), .ram(ram_req)
  );

  rom_arbiter rom_arbiter_inst (
    .CLK2(CLK2), .arst_n(arst_n), .bus(snes_bus), .dead(dead), .abort(abort),
    .req(rom_req), .rom_addr(rom_addr), .rom_rdata(rom_rdata), .rom_wdata(rom_wdata),
    .rom_data_oe(rom_data_oe), .rom_we_n(rom_we_n), .rom_bhe_n(rom_bhe_n),
    .rom_ble_n(rom_ble_n), .snes_rdata(snes_data_out)
  );

  ram_arbiter ram_arbiter_inst (
    .CLK2(CLK2), .arst_n(arst_n), .bus(snes_bus), .dead(dead), .abort(abort),
    .req(ram_req), .ram_addr(ram_addr), .ram_rdata(ram_rdata), .ram_wdata(ram_wdata),
    .ram_data_oe(ram_data_oe), .ram_we_n(ram_we_n)
  );

  // snes data bus driven only during its reads
  assign snes_data_oe = ~snes_bus.read;

endmodule

// File: cart_mem_sva.sv
`timescale 1ns/1ns

module cart_mem_sva (
  input logic CLK2,
  input logic arst_n,
  input logic mcu_rrq,
  input logic mcu_wrq,
  input logic mcu_rdy,
  input logic rom_we_n,
  input logic ram_we_n
);

  logic seen_req;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) seen_req <= 1'b0;
    else if (mcu_rrq | mcu_wrq) seen_req <= 1'b1;
  end

  // a write only happens inside an mcu access
  we_not_ready: assert property (@(posedge CLK2) disable iff (!arst_n)
    !((!rom_we_n || !ram_we_n) && mcu_rdy)) else $error("write enable low while ready");

  rdy_falls: assert property (@(posedge CLK2) disable iff (!arst_n)
    (mcu_rrq || mcu_wrq) |=> !mcu_rdy) else $error("mcu_rdy did not fall");

  rom_quiet: assert property (@(posedge CLK2) disable iff (!arst_n)
    !seen_req |-> rom_we_n) else $error("rom write before any request");

endmodule

bind cart_mem_top cart_mem_sva cart_mem_sva_inst (
  .CLK2(CLK2), .arst_n(arst_n), .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq),
  .mcu_rdy(mcu_rdy), .rom_we_n(rom_we_n), .ram_we_n(ram_we_n)
);

// File: tb_cart_mem.sv
`timescale 1ns/1ns
`include "cart_params.svh"

module tb_cart_mem;
  import cart_pkg::*;

  localparam int MAX_OPS = 64;

  logic CLK2 = 1'b0;
  logic arst_n;
  cart_addr_t snes_addr;
  logic snes_read_n;
  logic snes_romsel_n;
  logic snes_cpu_clk;
  byte_t snes_data_out;
  logic snes_data_oe;
  logic snes_reset_strobe;
  logic mcu_rrq;
  logic mcu_wrq;
  cart_addr_t mcu_addr;
  byte_t mcu_wdata;
  byte_t mcu_rdata;
  logic mcu_rdy;
  rom_addr_t rom_addr;
  rom_word_t rom_rdata;
  rom_word_t rom_wdata;
  logic rom_data_oe;
  logic rom_we_n;
  logic rom_bhe_n;
  logic rom_ble_n;
  ram_addr_t ram_addr;
  byte_t ram_rdata;
  byte_t ram_wdata;
  logic ram_data_oe;
  logic ram_we_n;

  logic [31:0] tdata [0:4*MAX_OPS-1];
  int n_ops = 0;
  logic snes_en = 1'b0;
  int snes_div = 0;
  int strobe_cnt = 0;
  int rom_wr_cycles = 0;
  rom_word_t rom_mem [rom_addr_t];
  byte_t ram_mem [ram_addr_t];

  cart_mem_top #(.DEAD_TIMEOUT(200)) cart_mem_top_inst (.*);

  always #10 CLK2 = ~CLK2;

  // --------------------
  // snes and memory models
  // --------------------

  // cpu clock toggles every 6 CLK2 cycles, parked low when stopped
  always @(posedge CLK2) begin
    if (!snes_en) begin
      snes_div <= 0;
      snes_cpu_clk <= 1'b0;
    end else if (snes_div == 5) begin
      snes_div <= 0;
      snes_cpu_clk <= ~snes_cpu_clk;
    end else begin
      snes_div <= snes_div + 1;
    end
  end

  always @(posedge CLK2) begin
    if (snes_reset_strobe) strobe_cnt <= strobe_cnt + 1;
  end

  // unwritten words hold a pattern of the full address
  function automatic rom_word_t rom_lookup(input rom_addr_t a);
    if (rom_mem.exists(a)) return rom_mem[a];
    return a[15:0] ^ {a[22:16], a[22:14]};
  endfunction

  function automatic byte_t ram_lookup(input ram_addr_t a);
    if (ram_mem.exists(a)) return ram_mem[a];
    return a[7:0] ^ a[18:11] ^ {5'b0, a[10:8]};
  endfunction

  always @(posedge CLK2) begin : rom_model
    rom_word_t w;
    rom_rdata <= rom_lookup(rom_addr);
    if (!rom_we_n) begin
      // write data must be on the bus while writing
      check_val("rom data oe", 32'd1, {31'd0, rom_data_oe});
      w = rom_lookup(rom_addr);
      if (!rom_ble_n) w[7:0] = rom_wdata[7:0];
      if (!rom_bhe_n) w[15:8] = rom_wdata[15:8];
      rom_mem[rom_addr] = w;
      rom_wr_cycles = rom_wr_cycles + 1;
    end
  end

  always @(posedge CLK2) begin
    ram_rdata <= ram_lookup(ram_addr);
    if (!ram_we_n) begin
      check_val("ram data oe", 32'd1, {31'd0, ram_data_oe});
      ram_mem[ram_addr] = ram_wdata;
    end
  end

  // --------------------
  // checks and operations
  // --------------------

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic mcu_access(input logic wr, input cart_addr_t a, input byte_t d);
    @(negedge CLK2);
    while (!mcu_rdy) @(negedge CLK2);
    @(posedge CLK2);
    mcu_rrq <= ~wr;
    mcu_wrq <= wr;
    mcu_addr <= a;
    mcu_wdata <= d;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    while (!mcu_rdy) @(negedge CLK2);
  endtask

  task automatic snes_read(input cart_addr_t a, input byte_t exp);
    @(posedge CLK2);
    snes_addr <= a;
    snes_read_n <= 1'b0;
    // filtered address lags by up to 7 cycles
    repeat (16) @(posedge CLK2);
    @(negedge CLK2);
    check_val("snes data oe", 32'd1, {31'd0, snes_data_oe});
    check_val("snes read", {24'd0, exp}, {24'd0, snes_data_out});
    @(posedge CLK2);
    snes_read_n <= 1'b1;
  endtask

  task automatic dead_restart(input logic [31:0] exp);
    int start_cnt;
    @(posedge CLK2);
    snes_en <= 1'b0;
    repeat (300) @(posedge CLK2);
    start_cnt = strobe_cnt;
    snes_en <= 1'b1;
    repeat (40) @(posedge CLK2);
    check_val("reset strobe count", exp, 32'(strobe_cnt - start_cnt));
  endtask

  task automatic run_op(input int i);
    logic [7:0] op;
    cart_addr_t a;
    byte_t d;
    byte_t e;
    rom_word_t w;
    int wr_before;
    op = tdata[4*i][7:0];
    a = tdata[4*i+1][23:0];
    d = tdata[4*i+2][7:0];
    e = tdata[4*i+3][7:0];
    wr_before = rom_wr_cycles;
    case (op)
      8'h00: begin
        mcu_access(1'b1, a, d);
        w = rom_lookup(a[23:1]);
        check_val("rom lane", {24'd0, d}, {24'd0, a[0] ? w[7:0] : w[15:8]});
      end
      8'h01: begin
        mcu_access(1'b0, a, 8'h00);
        check_val("rom read", {24'd0, e}, {24'd0, mcu_rdata});
      end
      8'h02: begin
        mcu_access(1'b1, a, d);
        check_val("ram model", {24'd0, d}, {24'd0, ram_lookup(a[18:0])});
        check_val("rom untouched", 32'(wr_before), 32'(rom_wr_cycles));
      end
      8'h03: begin
        mcu_access(1'b0, a, 8'h00);
        check_val("ram read", {24'd0, e}, {24'd0, mcu_rdata});
        check_val("rom untouched", 32'(wr_before), 32'(rom_wr_cycles));
      end
      8'h04: begin
        @(posedge CLK2);
        snes_en <= d[0];
        snes_romsel_n <= ~d[0];
        repeat (30) @(posedge CLK2);
      end
      8'h05: snes_read(a, e);
      8'h06: dead_restart({24'd0, e});
      default: begin
        $display("unknown operation code %h in test data", op);
        $display("SOME TESTS FAILED");
        $fatal(1, "bad test data");
      end
    endcase
  endtask

  // watchdog sized from the operation count
  initial begin
    wait (n_ops != 0);
    repeat (n_ops * 400) @(posedge CLK2);
    $display("run took too long, an access never completed");
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    arst_n = 1'b0;
    snes_addr = '0;
    snes_read_n = 1'b1;
    snes_romsel_n = 1'b1;
    snes_cpu_clk = 1'b0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    rom_rdata = '0;
    ram_rdata = '0;
    void'($urandom(32'hc947ffbe));
    $readmemh("cart_testdata.txt", tdata);
    while (n_ops < MAX_OPS && tdata[4*n_ops] !== 32'hff) n_ops++;
    repeat (4) @(posedge CLK2);
    arst_n <= 1'b1;
    repeat (2) @(posedge CLK2);
    @(negedge CLK2);
    check_val("reset mcu_rdy", 32'd1, {31'd0, mcu_rdy});
    check_val("reset rom_we_n", 32'd1, {31'd0, rom_we_n});
    check_val("reset ram_we_n", 32'd1, {31'd0, ram_we_n});
    check_val("reset rom_data_oe", 32'd0, {31'd0, rom_data_oe});
    check_val("reset ram_data_oe", 32'd0, {31'd0, ram_data_oe});
    check_val("reset snes_data_oe", 32'd0, {31'd0, snes_data_oe});
    check_val("reset strobe", 32'd0, {31'd0, snes_reset_strobe});
    for (int i = 0; i < n_ops; i++) begin
      repeat ($urandom_range(0, 5)) @(posedge CLK2);
      run_op(i);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: cart_testdata.txt
// columns: op addr data expected (hex)
// op 0 rom wr, 1 rom rd, 2 ram wr, 3 ram rd, 4 snes clk, 5 snes rd, 6 dead restart, ff end
00 001000 a5 00
00 001001 3c 00
00 02abce 5a 00
00 02abcf c3 00
01 001000 00 a5
01 001001 00 3c
01 02abce 00 5a
01 02abcf 00 c3
02 e00010 77 00
02 e7fff1 e1 00
03 e00010 00 77
03 e7fff1 00 e1
04 000000 01 00
05 001000 00 a5
05 001001 00 3c
00 001234 96 00
01 001234 00 96
03 e00010 00 77
05 02abcf 00 c3
06 000000 00 01
01 02abce 00 5a
ff 000000 00 00

// File: sources.f
+incdir+.
cart_pkg.sv
cart_if.sv
snes_bus_sync.sv
snes_dead_watch.sv
mcu_req_router.sv
rom_arbiter.sv
ram_arbiter.sv
cart_mem_top.sv
cart_mem_sva.sv
tb_cart_mem.sv

// File: Makefile
TOP = tb_cart_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
